//--- files.f
src/cache_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_if.sv
src/cache_control.sv
src/miss_counters.sv
src/cache_array.sv
src/victim_buffer.sv
src/data_cache.sv
test/tb_mem_model.sv
test/tb_data_cache.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line

rm -f sim.log

verilator --binary --timing -j 0 --top-module tb_data_cache -f files.f -o sim_data_cache \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_data_cache 2>&1 | tee sim.log

grep -q -F '*** PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src/cache_array.sv
`timescale 1ns/10ps

module cache_array
    import cache_pkg::*, cache_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    array_ctrl_if.array       ac,
    input  cache_addr_u       addr,
    input  logic [word_w-1:0] cpu_wdata,
    input  line_t             mem_line,
    input  line_t             victim_line,
    input  logic              victim_dirty,
    output logic [word_w-1:0] cpu_rdata,
    output line_t             evict_line,
    output logic [tag_w-1:0]  evict_tag,
    output logic              evict_dirty
);

    logic [tag_w-1:0]    tag_q   [2][num_sets];
    line_t               data_q  [2][num_sets];
    logic [1:0]          valid_q [num_sets];
    logic [1:0]          dirty_q [num_sets];
    logic [num_sets-1:0] lru_q;

    logic [index_w-1:0]  idx;
    logic [1:0]          word_sel;
    logic [1:0]          way_match;
    line_t               hit_line;
    line_t               merged_line;
    line_t               new_line;
    logic                new_dirty;

    assign idx      = addr.set_view.index;
    assign word_sel = addr.set_view.offset[offset_w-1:2];

    always_comb
    begin
        for (int w = 0; w < 2; w++)
            way_match[w] = valid_q[idx][w] && (tag_q[w][idx] == addr.set_view.tag);
    end

    assign ac.hit       = |way_match;
    assign ac.way_hit   = way_match[1];
    assign ac.lru       = lru_q[idx];
    assign ac.valid_out = valid_q[idx];
    assign ac.dirty_out = dirty_q[idx];

    assign hit_line  = data_q[ac.way_hit][idx];
    assign cpu_rdata = hit_line[word_sel*word_w +: word_w];

    assign evict_line  = data_q[ac.lru][idx];
    assign evict_tag   = tag_q[ac.lru][idx];
    assign evict_dirty = dirty_q[idx][ac.lru];

    always_comb
    begin
        merged_line = hit_line;
        merged_line[word_sel*word_w +: word_w] = cpu_wdata;
    end

    always_comb
    begin
        case (ac.line_src)
            cpu_word:                    new_line = merged_line;
            cache_ctrl_pkg::victim_line: new_line = victim_line;
            default:                     new_line = mem_line;
        endcase
    end

    // a swapped-in line brings its own dirty bit
    assign new_dirty = (ac.line_src == cache_ctrl_pkg::victim_line) ? victim_dirty : ac.dirty_in;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < num_sets; s++)
            begin
                valid_q[s] <= 2'b00;
                dirty_q[s] <= 2'b00;
            end
            lru_q <= '0;
        end
        else
        begin
            for (int w = 0; w < 2; w++)
            begin
                if (ac.ld_valid[w])
                    valid_q[idx][w] <= ac.valid_in;
                if (ac.ld_dirty[w])
                    dirty_q[idx][w] <= new_dirty;
            end
            if (ac.ld_lru)
                lru_q[idx] <= ac.lru_in;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < 2; w++)
        begin
            if (ac.ld_tag[w])
                tag_q[w][idx] <= addr.set_view.tag;
            if (ac.ld_data[w])
                data_q[w][idx] <= new_line;
        end
    end

endmodule

//--- src/cache_control.sv
`timescale 1ns/10ps

module cache_control
    import cache_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           cpu_read,
    input  logic           cpu_write,
    output logic           cpu_resp,
    array_ctrl_if.control  ac,
    victim_ctrl_if.control vc,
    output logic           pmem_read,
    output logic           pmem_write,
    input  logic           pmem_resp,
    output logic           miss_event,
    output logic           victim_event
);

    ctrl_state_e state;
    ctrl_state_e next_state;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state      = state;
        cpu_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        miss_event      = 1'b0;
        victim_event    = 1'b0;
        ac.ld_tag       = 2'b00;
        ac.ld_valid     = 2'b00;
        ac.ld_dirty     = 2'b00;
        ac.valid_in     = 1'b0;
        ac.dirty_in     = 1'b0;
        ac.ld_lru       = 1'b0;
        ac.lru_in       = 1'b0;
        ac.ld_data      = 2'b00;
        ac.line_src     = cpu_word;
        vc.ld_entry     = 2'b00;
        vc.valid_in     = 1'b0;
        vc.dirty_in     = 1'b0;
        vc.ld_lru       = 1'b0;
        vc.lru_in       = 1'b0;
        vc.use_hit_slot = 1'b0;

        case (state)
            idle:
            begin
                if (cpu_read || cpu_write)
                    next_state = check;
            end
            check:
            begin
                if (ac.hit)
                begin
                    cpu_resp  = 1'b1;
                    ac.ld_lru = 1'b1;
                    ac.lru_in = ~ac.way_hit;
                    // write hit merges the word and marks the line dirty
                    if (cpu_write)
                    begin
                        ac.ld_data[ac.way_hit]  = 1'b1;
                        ac.ld_dirty[ac.way_hit] = 1'b1;
                        ac.dirty_in             = 1'b1;
                    end
                    next_state = idle;
                end
                else if (vc.victim_hit)
                begin
                    victim_event = 1'b1;
                    next_state   = cache_to_victim;
                end
                else
                begin
                    miss_event = 1'b1;
                    next_state = evict_select;
                end
            end
            cache_to_victim:
            begin
                // main lru line takes the slot that hit
                vc.use_hit_slot          = 1'b1;
                vc.ld_entry[vc.slot_hit] = 1'b1;
                vc.valid_in              = ac.valid_out[ac.lru];
                vc.dirty_in              = 1'b1;
                vc.ld_lru                = 1'b1;
                vc.lru_in                = ~vc.slot_hit;
                next_state               = victim_to_cache;
            end
            victim_to_cache:
            begin
                ac.line_src         = victim_line;
                ac.ld_data[ac.lru]  = 1'b1;
                ac.ld_tag[ac.lru]   = 1'b1;
                ac.ld_valid[ac.lru] = 1'b1;
                ac.ld_dirty[ac.lru] = 1'b1;
                ac.valid_in         = 1'b1;
                next_state          = check;
            end
            evict_select:
            begin
                if (!ac.valid_out[ac.lru])
                    next_state = fill;
                else if (vc.valid_out[vc.lru] && vc.dirty_out[vc.lru])
                    next_state = write_back;
                else
                    next_state = write_to_victim;
            end
            write_back:
            begin
                pmem_write = 1'b1;
                if (pmem_resp)
                    next_state = write_to_victim;
            end
            write_to_victim:
            begin
                vc.ld_entry[vc.lru] = 1'b1;
                vc.valid_in         = 1'b1;
                vc.dirty_in         = 1'b1;
                vc.ld_lru           = 1'b1;
                vc.lru_in           = ~vc.lru;
                next_state          = fill;
            end
            fill:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ac.line_src         = mem_line;
                    ac.ld_data[ac.lru]  = 1'b1;
                    ac.ld_tag[ac.lru]   = 1'b1;
                    ac.ld_valid[ac.lru] = 1'b1;
                    ac.ld_dirty[ac.lru] = 1'b1;
                    ac.valid_in         = 1'b1;
                    ac.dirty_in         = 1'b0;
                    next_state          = check;
                end
            end
            default:
            begin
                next_state = idle;
            end
        endcase
    end

endmodule

//--- src/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        idle,
        check,
        cache_to_victim,
        victim_to_cache,
        evict_select,
        write_back,
        write_to_victim,
        fill
    } ctrl_state_e;

    // source of a line written into the main array
    typedef enum logic [1:0] {
        cpu_word,
        victim_line,
        mem_line
    } line_src_e;

endpackage

//--- src/cache_if.sv
`timescale 1ns/10ps

interface array_ctrl_if
    import cache_ctrl_pkg::*;
();
    logic [1:0] ld_tag;
    logic [1:0] ld_valid;
    logic [1:0] ld_dirty;
    logic       valid_in;
    logic       dirty_in;
    logic       ld_lru;
    logic       lru_in;
    logic [1:0] ld_data;
    line_src_e  line_src;

    logic       hit;
    logic       way_hit;
    logic       lru;
    logic [1:0] valid_out;
    logic [1:0] dirty_out;

    modport control (
        output ld_tag, ld_valid, ld_dirty, valid_in, dirty_in,
        output ld_lru, lru_in, ld_data, line_src,
        input  hit, way_hit, lru, valid_out, dirty_out
    );

    modport array (
        input  ld_tag, ld_valid, ld_dirty, valid_in, dirty_in,
        input  ld_lru, lru_in, ld_data, line_src,
        output hit, way_hit, lru, valid_out, dirty_out
    );
endinterface

interface victim_ctrl_if ();
    logic [1:0] ld_entry;
    logic       valid_in;
    logic       dirty_in;
    logic       ld_lru;
    logic       lru_in;
    logic       use_hit_slot;

    logic       victim_hit;
    logic       slot_hit;
    logic       lru;
    logic [1:0] valid_out;
    logic [1:0] dirty_out;

    modport control (
        output ld_entry, valid_in, dirty_in, ld_lru, lru_in, use_hit_slot,
        input  victim_hit, slot_hit, lru, valid_out, dirty_out
    );

    modport buffer (
        input  ld_entry, valid_in, dirty_in, ld_lru, lru_in, use_hit_slot,
        output victim_hit, slot_hit, lru, valid_out, dirty_out
    );
endinterface

//--- src/cache_pkg.sv
package cache_pkg;

    localparam int addr_w     = 32;
    localparam int word_w     = 32;
    localparam int line_words = 4;
    localparam int line_w     = 128;
    localparam int num_sets   = 8;
    localparam int index_w    = 3;
    localparam int offset_w   = 4;
    localparam int tag_w      = 25;

    // whole line address, used by the victim buffer
    localparam int line_tag_w = 28;

    typedef logic [line_w-1:0] line_t;

    // set_view indexes the main array, line_view matches victim slots
    typedef union packed {
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;
        } set_view;
        struct packed {
            logic [line_tag_w-1:0] line_tag;
            logic [offset_w-1:0]   offset;
        } line_view;
    } cache_addr_u;

endpackage

//--- src/data_cache.sv
`timescale 1ns/10ps

module data_cache
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_read,
    input  logic              cpu_write,
    input  logic [addr_w-1:0] cpu_addr,
    input  logic [word_w-1:0] cpu_wdata,
    output logic [word_w-1:0] cpu_rdata,
    output logic              cpu_resp,
    output logic              pmem_read,
    output logic              pmem_write,
    output logic [addr_w-1:0] pmem_addr,
    output line_t             pmem_wdata,
    input  line_t             pmem_rdata,
    input  logic              pmem_resp,
    output logic [31:0]       miss_count,
    output logic [31:0]       victim_hit_count
);

    array_ctrl_if  ac ();
    victim_ctrl_if vc ();

    cache_addr_u       addr;
    line_t             evict_line;
    logic [tag_w-1:0]  evict_tag;
    logic              evict_dirty;
    line_t             swap_line;
    logic              swap_dirty;
    line_t             wb_line;
    logic [addr_w-1:0] wb_addr;
    logic              miss_event;
    logic              victim_event;

    assign addr = cpu_addr;

    // write-back uses the victim's address, a fill the requested line
    assign pmem_addr  = pmem_write ? wb_addr : {addr.line_view.line_tag, {offset_w{1'b0}}};
    assign pmem_wdata = wb_line;

    cache_control ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .cpu_read     (cpu_read),
        .cpu_write    (cpu_write),
        .cpu_resp     (cpu_resp),
        .ac           (ac.control),
        .vc           (vc.control),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_resp    (pmem_resp),
        .miss_event   (miss_event),
        .victim_event (victim_event)
    );

    miss_counters counters0 (
        .clk              (clk),
        .rst              (rst),
        .miss_event       (miss_event),
        .victim_event     (victim_event),
        .miss_count       (miss_count),
        .victim_hit_count (victim_hit_count)
    );

    cache_array array0 (
        .clk          (clk),
        .rst          (rst),
        .ac           (ac.array),
        .addr         (addr),
        .cpu_wdata    (cpu_wdata),
        .mem_line     (pmem_rdata),
        .victim_line  (swap_line),
        .victim_dirty (swap_dirty),
        .cpu_rdata    (cpu_rdata),
        .evict_line   (evict_line),
        .evict_tag    (evict_tag),
        .evict_dirty  (evict_dirty)
    );

    victim_buffer victims0 (
        .clk         (clk),
        .rst         (rst),
        .vc          (vc.buffer),
        .addr        (addr),
        .evict_line  (evict_line),
        .evict_tag   (evict_tag),
        .evict_index (addr.set_view.index),
        .evict_dirty (evict_dirty),
        .swap_line   (swap_line),
        .swap_dirty  (swap_dirty),
        .wb_line     (wb_line),
        .wb_addr     (wb_addr)
    );

endmodule

//--- src/miss_counters.sv
`timescale 1ns/10ps

module miss_counters (
    input  logic        clk,
    input  logic        rst,
    input  logic        miss_event,
    input  logic        victim_event,
    output logic [31:0] miss_count,
    output logic [31:0] victim_hit_count
);

    // both counts stick at all ones
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            miss_count       <= '0;
            victim_hit_count <= '0;
        end
        else
        begin
            if (miss_event && (miss_count != '1))
                miss_count <= miss_count + 32'd1;
            if (victim_event && (victim_hit_count != '1))
                victim_hit_count <= victim_hit_count + 32'd1;
        end
    end

endmodule

//--- src/victim_buffer.sv
`timescale 1ns/10ps

module victim_buffer
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    victim_ctrl_if.buffer      vc,
    input  cache_addr_u        addr,
    input  line_t              evict_line,
    input  logic [tag_w-1:0]   evict_tag,
    input  logic [index_w-1:0] evict_index,
    input  logic               evict_dirty,
    output line_t              swap_line,
    output logic               swap_dirty,
    output line_t              wb_line,
    output logic [addr_w-1:0]  wb_addr
);

    logic [line_tag_w-1:0] tag_q  [2];
    line_t                 data_q [2];
    logic [1:0]            valid_q;
    logic [1:0]            dirty_q;
    logic                  lru_q;

    logic [1:0]            slot_match;
    logic                  wr_slot;
    logic                  wr_en;

    always_comb
    begin
        for (int i = 0; i < 2; i++)
            slot_match[i] = valid_q[i] && (tag_q[i] == addr.line_view.line_tag);
    end

    assign vc.victim_hit = |slot_match;
    assign vc.slot_hit   = slot_match[1];
    assign vc.lru        = lru_q;
    assign vc.valid_out  = valid_q;
    assign vc.dirty_out  = dirty_q;

    assign wr_slot = vc.use_hit_slot ? vc.slot_hit : lru_q;
    assign wr_en   = vc.ld_entry[wr_slot];

    // lru slot is the next one to leave
    assign wb_line = data_q[lru_q];
    assign wb_addr = {tag_q[lru_q], {offset_w{1'b0}}};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= 2'b00;
            dirty_q <= 2'b00;
            lru_q   <= 1'b0;
        end
        else
        begin
            if (wr_en)
            begin
                valid_q[wr_slot] <= vc.valid_in;
                dirty_q[wr_slot] <= vc.dirty_in & evict_dirty;
            end
            if (vc.ld_lru)
                lru_q <= vc.lru_in;
        end
    end

    // hit slot is captured before the swap overwrites it
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tag_q[wr_slot]  <= {evict_tag, evict_index};
            data_q[wr_slot] <= evict_line;
        end
        if (vc.victim_hit)
        begin
            swap_line  <= data_q[vc.slot_hit];
            swap_dirty <= dirty_q[vc.slot_hit];
        end
    end

endmodule

//--- test/tb_data_cache.sv
`timescale 1ns/10ps

module tb_data_cache
    import cache_pkg::*;
();

    localparam int random_ops     = 400;
    localparam int total_requests = 20 + random_ops;

    logic              clk;
    logic              rst;
    logic              cpu_read;
    logic              cpu_write;
    logic [addr_w-1:0] cpu_addr;
    logic [word_w-1:0] cpu_wdata;
    logic [word_w-1:0] cpu_rdata;
    logic              cpu_resp;
    logic              pmem_read;
    logic              pmem_write;
    logic [addr_w-1:0] pmem_addr;
    line_t             pmem_wdata;
    line_t             pmem_rdata;
    logic              pmem_resp;
    logic [31:0]       miss_count;
    logic [31:0]       victim_hit_count;

    // shadow state of the main array and the victim buffer
    logic [tag_w-1:0]      m_tag [2][num_sets];
    logic [1:0]            m_valid [num_sets];
    logic [1:0]            m_dirty [num_sets];
    logic [num_sets-1:0]   m_lru;
    logic [line_tag_w-1:0] v_tag [2];
    logic [1:0]            v_valid;
    logic [1:0]            v_dirty;
    logic                  v_lru;
    logic [word_w-1:0]     shadow [1024];
    logic [31:0]           exp_miss;
    logic [31:0]           exp_victim;
    logic [31:0]           exp_wb;

    logic [word_w-1:0]     expect_q [$];
    logic [31:0]           wb_count;
    logic [31:0]           requests;
    logic [31:0]           responses;
    int                    errors;
    int                    test_start_errors;
    int                    tests;

    data_cache dut0 (
        .clk              (clk),
        .rst              (rst),
        .cpu_read         (cpu_read),
        .cpu_write        (cpu_write),
        .cpu_addr         (cpu_addr),
        .cpu_wdata        (cpu_wdata),
        .cpu_rdata        (cpu_rdata),
        .cpu_resp         (cpu_resp),
        .pmem_read        (pmem_read),
        .pmem_write       (pmem_write),
        .pmem_addr        (pmem_addr),
        .pmem_wdata       (pmem_wdata),
        .pmem_rdata       (pmem_rdata),
        .pmem_resp        (pmem_resp),
        .miss_count       (miss_count),
        .victim_hit_count (victim_hit_count)
    );

    tb_mem_model mem0 (
        .clk   (clk),
        .rst   (rst),
        .read  (pmem_read),
        .write (pmem_write),
        .addr  (pmem_addr),
        .wdata (pmem_wdata),
        .rdata (pmem_rdata),
        .resp  (pmem_resp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [word_w-1:0] pattern_word(input logic [addr_w-1:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    task automatic reset_model();
        for (int s = 0; s < num_sets; s++)
        begin
            m_tag[0][s] = '0;
            m_tag[1][s] = '0;
            m_valid[s]  = 2'b00;
            m_dirty[s]  = 2'b00;
        end
        m_lru    = '0;
        v_tag[0] = '0;
        v_tag[1] = '0;
        v_valid  = 2'b00;
        v_dirty  = 2'b00;
        v_lru    = 1'b0;
        for (int i = 0; i < 1024; i++)
            shadow[i] = pattern_word({20'd0, i[9:0], 2'b00});
        exp_miss   = '0;
        exp_victim = '0;
        exp_wb     = '0;
    endtask

    // expected read word; also steps the shadow tags, LRU and counts
    function automatic logic [word_w-1:0] model_access(input logic [addr_w-1:0] a,
                                                        input logic              is_write,
                                                        input logic [word_w-1:0] d);
        logic [index_w-1:0]    idx;
        logic [tag_w-1:0]      tag;
        logic [line_tag_w-1:0] ltag;
        logic [9:0]            word;
        logic                  found;
        logic                  way;
        logic                  v_found;
        logic                  slot;
        logic                  old_dirty;

        idx     = a[6:4];
        tag     = a[31:7];
        ltag    = a[31:4];
        word    = a[11:2];
        found   = 1'b0;
        way     = 1'b0;
        v_found = 1'b0;
        slot    = 1'b0;
        for (int w = 0; w < 2; w++)
        begin
            if (m_valid[idx][w] && (m_tag[w][idx] == tag))
            begin
                found = 1'b1;
                way   = w[0];
            end
        end
        for (int s = 0; s < 2; s++)
        begin
            if (v_valid[s] && (v_tag[s] == ltag))
            begin
                v_found = 1'b1;
                slot    = s[0];
            end
        end
        if (!found)
        begin
            way = m_lru[idx];
            if (v_found)
            begin
                // swap the lru way with the slot that hit
                exp_victim        = exp_victim + 32'd1;
                old_dirty         = v_dirty[slot];
                v_tag[slot]       = {m_tag[way][idx], idx};
                v_valid[slot]     = m_valid[idx][way];
                v_dirty[slot]     = m_dirty[idx][way];
                v_lru             = ~slot;
                m_dirty[idx][way] = old_dirty;
            end
            else
            begin
                exp_miss = exp_miss + 32'd1;
                if (m_valid[idx][way])
                begin
                    if (v_valid[v_lru] && v_dirty[v_lru])
                        exp_wb = exp_wb + 32'd1;
                    v_tag[v_lru]   = {m_tag[way][idx], idx};
                    v_valid[v_lru] = 1'b1;
                    v_dirty[v_lru] = m_dirty[idx][way];
                    v_lru          = ~v_lru;
                end
                m_dirty[idx][way] = 1'b0;
            end
            m_tag[way][idx]   = tag;
            m_valid[idx][way] = 1'b1;
        end
        m_lru[idx] = ~way;
        if (is_write)
        begin
            m_dirty[idx][way] = 1'b1;
            shadow[word]      = d;
        end
        return shadow[word];
    endfunction

    task automatic compare_word(input logic [word_w-1:0] got, input logic [word_w-1:0] exp,
                                input string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_count(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // one request, held until cpu_resp; cycles counts from the idle cycle
    task automatic issue(input logic [addr_w-1:0] a, input logic is_write,
                         input logic [word_w-1:0] d, output logic [31:0] cycles);
        logic [word_w-1:0] exp_data;

        exp_data = model_access(a, is_write, d);
        if (!is_write)
            expect_q.push_back(exp_data);
        requests  = requests + 32'd1;
        cpu_addr  = a;
        cpu_wdata = d;
        cpu_read  = !is_write;
        cpu_write = is_write;
        cycles    = 32'd1;
        @(negedge clk);
        while (!cpu_resp)
        begin
            @(negedge clk);
            cycles = cycles + 32'd1;
        end
        @(posedge clk);
        #1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_start_errors)
            $display("test %0d, %s: ok", tests, name);
        else
            $display("test %0d, %s: failed with %0d errors", tests, name,
                     errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic cold_read_then_hit();
        logic [31:0] cycles;

        issue(32'h0000_0040, 1'b0, '0, cycles);
        issue(32'h0000_0040, 1'b0, '0, cycles);
        compare_count(cycles, 32'd2, "hit latency");
        compare_count(miss_count, exp_miss, "miss count");
        report_test("cold read, then hit");
    endtask

    task automatic write_then_read();
        logic [31:0] cycles;
        logic [31:0] m0;

        m0 = miss_count;
        issue(32'h0000_01b8, 1'b1, 32'hdead_beef, cycles);
        compare_count(miss_count, m0 + 32'd1, "miss count after write");
        issue(32'h0000_01b8, 1'b0, '0, cycles);
        compare_count(miss_count, m0 + 32'd1, "miss count after read");
        report_test("write, then read back");
    endtask

    task automatic victim_swap();
        logic [31:0] cycles;
        logic [31:0] m0;
        logic [31:0] v0;

        m0 = miss_count;
        v0 = victim_hit_count;
        // three tags in set 2
        issue(32'h0000_0020, 1'b0, '0, cycles);
        issue(32'h0000_00a0, 1'b0, '0, cycles);
        issue(32'h0000_0120, 1'b0, '0, cycles);
        issue(32'h0000_0020, 1'b0, '0, cycles);
        compare_count(cycles, 32'd5, "victim hit latency");
        compare_count(victim_hit_count, v0 + 32'd1, "victim hit count");
        compare_count(miss_count, m0 + 32'd3, "miss count");
        report_test("victim swap");
    endtask

    task automatic dirty_write_back();
        logic [31:0]       cycles;
        logic [addr_w-1:0] a;

        // six dirty lines in set 5 push lines through the victim buffer
        for (int k = 0; k < 6; k++)
        begin
            a = 32'h0000_0050 + 32'(k) * 32'h80 + 32'(k % 4) * 32'd4;
            issue(a, 1'b1, 32'h0bad_0000 + 32'(k), cycles);
        end
        for (int k = 0; k < 6; k++)
        begin
            a = 32'h0000_0050 + 32'(k) * 32'h80 + 32'(k % 4) * 32'd4;
            issue(a, 1'b0, '0, cycles);
        end
        compare_count(wb_count, exp_wb, "write-back count");
        compare_count(miss_count, exp_miss, "miss count");
        report_test("dirty write-back");
    endtask

    task automatic run_random_test();
        logic [31:0]       cycles;
        logic [31:0]       rnd;
        logic [addr_w-1:0] a;
        int                line_no;

        for (int n = 0; n < random_ops; n++)
        begin
            rnd     = $urandom;
            line_no = int'($urandom % 32'd24) * 7;
            a       = {20'd0, line_no[7:0], rnd[1:0], 2'b00};
            issue(a, (rnd[4:2] < 3'd3), $urandom, cycles);
        end
        compare_count(miss_count, exp_miss, "miss count");
        compare_count(victim_hit_count, exp_victim, "victim hit count");
        compare_count(wb_count, exp_wb, "write-back count");
        report_test("random reads and writes");
    endtask

    // read data is checked against the model in the response cycle
    always @(negedge clk)
    begin
        if (!rst && pmem_write && pmem_resp)
            wb_count = wb_count + 32'd1;
        if (!rst && cpu_resp)
        begin
            responses = responses + 32'd1;
            if (cpu_read)
            begin
                if (expect_q.size() == 0)
                begin
                    $display("read response at %0t with no read outstanding", $time);
                    errors++;
                end
                else
                begin
                    compare_word(cpu_rdata, expect_q.pop_front(), "read data");
                end
            end
        end
    end

    initial
    begin
        repeat (total_requests * 200) @(posedge clk);
        $display("timeout: requests stalled for %0d cycles", total_requests * 200);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h70d6));
        rst               = 1'b1;
        cpu_read          = 1'b0;
        cpu_write         = 1'b0;
        cpu_addr          = '0;
        cpu_wdata         = '0;
        wb_count          = '0;
        requests          = '0;
        responses         = '0;
        errors            = 0;
        test_start_errors = 0;
        tests             = 0;
        reset_model();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_count(miss_count, 32'd0, "miss count after reset");
        compare_count(victim_hit_count, 32'd0, "victim hit count after reset");

        cold_read_then_hit();
        write_then_read();
        victim_swap();
        dirty_write_back();
        run_random_test();

        compare_count(responses, requests, "response count");
        $display("%0d tests, %0d requests, %0d responses, %0d write-backs, %0d errors",
                 tests, requests, responses, wb_count, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- test/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              read,
    input  logic              write,
    input  logic [addr_w-1:0] addr,
    input  line_t             wdata,
    output line_t             rdata,
    output logic              resp
);

    line_t mem [256];
    logic  busy;
    int    wait_left;

    function automatic logic [word_w-1:0] pattern_word(input logic [addr_w-1:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    initial
    begin
        for (int l = 0; l < 256; l++)
        begin
            for (int w = 0; w < line_words; w++)
                mem[l][w*word_w +: word_w] = pattern_word({20'd0, l[7:0], w[1:0], 2'b00});
        end
        rdata     = '0;
        resp      = 1'b0;
        busy      = 1'b0;
        wait_left = 0;
    end

    // outputs change 1 ns after the edge, like the rest of the stimulus
    always @(posedge clk)
    begin
        #1;
        resp = 1'b0;
        if (rst)
        begin
            busy = 1'b0;
        end
        else if (read || write)
        begin
            if (!busy)
            begin
                busy      = 1'b1;
                wait_left = int'($urandom % 32'd6);
            end
            else if (wait_left > 0)
            begin
                wait_left = wait_left - 1;
            end
            if (busy && (wait_left == 0))
            begin
                if (write)
                    mem[addr[11:4]] = wdata;
                if (read)
                    rdata = mem[addr[11:4]];
                resp = 1'b1;
                busy = 1'b0;
            end
        end
    end

endmodule
